// ==== source/alut_pkg.sv ====
package alut_pkg;

   // --------------------------------------------------------------------
   // table entry layout
   // --------------------------------------------------------------------
   localparam int entry_w   = 83;
   localparam int valid_bit = 82;     // entry holds a learned address
   localparam int time_msb  = 81;
   localparam int time_lsb  = 50;     // time of last access
   localparam int port_msb  = 49;
   localparam int port_lsb  = 48;     // switch port
   localparam int mac_msb   = 47;     // mac sits in 47:0

   typedef logic [entry_w-1:0] alut_entry_t;

   // --------------------------------------------------------------------
   // age checker commands
   // --------------------------------------------------------------------
   typedef logic [1:0] alut_cmd_t;

   localparam alut_cmd_t cmd_none       = 2'b00;
   localparam alut_cmd_t cmd_inval_aged = 2'b10;   // clear out of date entries
   localparam alut_cmd_t cmd_inval_all  = 2'b11;   // clear whole table

   // age checker fsm states
   typedef enum logic [2:0] {
      idle          = 3'b000,
      inval_aged_rd = 3'b001,   // present next sweep address
      inval_aged_wr = 3'b010,   // clear aged entry
      inval_all     = 3'b011,   // zero fill
      age_chk       = 3'b100    // judge one time stamp
   } age_state_t;

endpackage

// ==== source/alut_mem.sv ====
`timescale 1ns/1ps

module alut_mem #(
   parameter int addr_w = 8                           // table index width
) (
   input  logic                  pclk5,
   input  logic                  n_p_reset5,
   input  logic                  add_check_active,    // address checker owns the port
   input  logic [addr_w-1:0]     addr_chk_addr,
   input  logic                  addr_chk_write,
   input  alut_pkg::alut_entry_t addr_chk_wdata,
   input  logic [addr_w-1:0]     age_addr,
   input  logic                  age_write,
   input  alut_pkg::alut_entry_t age_wdata,
   output alut_pkg::alut_entry_t read_data            // entry at owner address
);

   localparam int depth = 1 << addr_w;

   alut_pkg::alut_entry_t mem [depth];
   logic [addr_w-1:0]     sel_addr;
   logic                  sel_write;
   alut_pkg::alut_entry_t sel_wdata;

   // single port, owner picked by the address checker activity flag
   assign sel_addr  = add_check_active ? addr_chk_addr  : age_addr;
   assign sel_write = add_check_active ? addr_chk_write : age_write;
   assign sel_wdata = add_check_active ? addr_chk_wdata : age_wdata;

   always_ff @(posedge pclk5 or negedge n_p_reset5)
   begin
      if (!n_p_reset5)
      begin
         for (int i = 0; i < depth; i++)
            mem[i] <= '0;                             // whole table invalid
      end
      else if (sel_write)
         mem[sel_addr] <= sel_wdata;
   end

   assign read_data = mem[sel_addr];                  // no read latency

endmodule

// ==== source/alut_age_checker.sv ====
`timescale 1ns/1ps

module alut_age_checker #(
   parameter int addr_w = 8                           // table index width
) (
   input  logic                  pclk5,
   input  logic                  n_p_reset5,
   input  alut_pkg::alut_cmd_t   command,             // one cycle command pulse
   input  logic [7:0]            div_clk,             // time base divider
   input  alut_pkg::alut_entry_t mem_read_data,
   input  logic                  check_age,           // query from address checker
   input  logic [31:0]           last_accessed,       // time stamp under query
   input  logic [31:0]           best_bfr_age,
   input  logic                  add_check_active,
   output logic [31:0]           curr_time,
   output logic [addr_w-1:0]     mem_addr_age,
   output logic                  mem_write_age,
   output alut_pkg::alut_entry_t mem_write_data_age,
   output logic [47:0]           lst_inv_addr,        // mac of last aged clear
   output logic [1:0]            lst_inv_port,
   output logic                  age_confirmed,       // qualifies age_ok
   output logic                  age_ok,              // high means in date
   output logic                  inval_in_prog,
   output logic                  age_check_active
);

   localparam logic [addr_w-1:0] max_addr = '1;

   alut_pkg::age_state_t state;
   alut_pkg::age_state_t nxt_state;
   logic [7:0]           div_cnt;
   logic                 tick;                        // time base advance
   logic                 at_max;                      // sweep on last address
   logic [31:0]          judged_time;
   logic [31:0]          elapsed;

   // --------------------------------------------------------------------
   // time base
   // --------------------------------------------------------------------
   assign tick = (div_cnt == div_clk);

   always_ff @(posedge pclk5 or negedge n_p_reset5)
   begin
      if (!n_p_reset5)
      begin
         div_cnt   <= '0;
         curr_time <= '0;
      end
      else if (tick)
      begin
         div_cnt   <= '0;
         curr_time <= curr_time + 32'd1;              // one step per div_clk+1 clocks
      end
      else
         div_cnt <= div_cnt + 8'd1;
   end

   // --------------------------------------------------------------------
   // state machine
   // --------------------------------------------------------------------
   assign at_max = (mem_addr_age == max_addr);

   always_comb
   begin
      nxt_state = state;
      case (state)
         alut_pkg::idle:
            if (!add_check_active && command == alut_pkg::cmd_inval_aged)
               nxt_state = alut_pkg::inval_aged_rd;
            else if (!add_check_active && command == alut_pkg::cmd_inval_all)
               nxt_state = alut_pkg::inval_all;
            else if (check_age)
               nxt_state = alut_pkg::age_chk;
         alut_pkg::inval_aged_rd:
            nxt_state = alut_pkg::age_chk;
         alut_pkg::inval_aged_wr:
            nxt_state = at_max ? alut_pkg::idle : alut_pkg::inval_aged_rd;
         alut_pkg::inval_all:
            if (at_max)
               nxt_state = alut_pkg::idle;            // last zero written
         alut_pkg::age_chk:
            if (age_confirmed)
            begin
               if (add_check_active)
                  nxt_state = alut_pkg::idle;         // query answered
               else if (mem_read_data[alut_pkg::valid_bit] && !age_ok)
                  nxt_state = alut_pkg::inval_aged_wr;
               else if (at_max)
                  nxt_state = alut_pkg::idle;         // sweep done
               else
                  nxt_state = alut_pkg::inval_aged_rd;
            end
         default:
            nxt_state = alut_pkg::idle;
      endcase
   end

   always_ff @(posedge pclk5 or negedge n_p_reset5)
   begin
      if (!n_p_reset5)
         state <= alut_pkg::idle;
      else
         state <= nxt_state;
   end

   assign age_check_active = (state != alut_pkg::idle);

   // --------------------------------------------------------------------
   // sweep bus, every sweep starts from address 0
   // --------------------------------------------------------------------
   always_ff @(posedge pclk5 or negedge n_p_reset5)
   begin
      if (!n_p_reset5)
         mem_addr_age <= '0;
      else if (state == alut_pkg::idle)
         mem_addr_age <= '0;
      else if (state == alut_pkg::inval_all || nxt_state == alut_pkg::inval_aged_rd)
         mem_addr_age <= mem_addr_age + 1'b1;         // step to next slot
   end

   assign mem_write_age = (state == alut_pkg::inval_aged_wr) ||
                          (state == alut_pkg::inval_all);
   assign mem_write_data_age = '0;                    // clears only

   // age judgement, query stamp or stamp read back from the table
   assign judged_time = add_check_active ? last_accessed
                      : mem_read_data[alut_pkg::time_msb:alut_pkg::time_lsb];
   assign elapsed = curr_time - judged_time;          // modulo 2^32

   always_ff @(posedge pclk5 or negedge n_p_reset5)
   begin
      if (!n_p_reset5)
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
      else if (state == alut_pkg::age_chk && !age_confirmed)
      begin
         age_confirmed <= 1'b1;
         age_ok        <= (best_bfr_age > elapsed);
      end
      else
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
   end

   // --------------------------------------------------------------------
   // invalidation status
   // --------------------------------------------------------------------
   always_ff @(posedge pclk5 or negedge n_p_reset5)
   begin
      if (!n_p_reset5)
         inval_in_prog <= 1'b0;
      else if (state == alut_pkg::inval_aged_wr && !at_max)
         inval_in_prog <= 1'b1;                       // first aged clear
      else if (state == alut_pkg::age_chk && !add_check_active && at_max)
         inval_in_prog <= 1'b0;
   end

   always_ff @(posedge pclk5 or negedge n_p_reset5)
   begin
      if (!n_p_reset5)
      begin
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if (state == alut_pkg::inval_aged_wr)     // old entry still on read bus
      begin
         lst_inv_addr <= mem_read_data[alut_pkg::mac_msb:0];
         lst_inv_port <= mem_read_data[alut_pkg::port_msb:alut_pkg::port_lsb];
      end
   end

endmodule

// ==== source/alut_addr_checker.sv ====
`timescale 1ns/1ps

module alut_addr_checker #(
   parameter int addr_w = 8                           // table index width
) (
   input  logic                  pclk5,
   input  logic                  n_p_reset5,
   input  logic                  pkt_valid,           // packet strobe
   input  logic [47:0]           src_addr,
   input  logic [1:0]            src_port,
   input  logic [47:0]           dst_addr,
   input  alut_pkg::alut_entry_t mem_read_data,
   input  logic                  age_confirmed,
   input  logic                  age_ok,
   input  logic                  age_check_active,
   input  logic [31:0]           curr_time,
   output logic                  ready,
   output logic                  lookup_done,
   output logic                  dst_found,
   output logic [1:0]            dst_port,
   output logic                  check_age,           // age query pulse
   output logic [31:0]           last_accessed,       // stamp of matched entry
   output logic                  add_check_active,    // held through learn write
   output logic [addr_w-1:0]     mem_addr,
   output logic                  mem_write,
   output alut_pkg::alut_entry_t mem_write_data
);

   typedef enum logic [2:0] {
      st_init,                                        // one cycle out of reset
      st_idle,
      st_wait,                                        // waiting on age answer
      st_result,
      st_learn
   } ac_state_t;

   ac_state_t   state;
   ac_state_t   nxt_state;
   logic        accept;
   logic        hit;                                  // valid entry, same mac
   logic [47:0] src_addr_q;
   logic [1:0]  src_port_q;

   // table index, low bits folded with the next slice
   function automatic logic [addr_w-1:0] hash_idx(input logic [47:0] mac);
      return mac[addr_w-1:0] ^ mac[2*addr_w-1:addr_w];
   endfunction

   assign ready  = (state == st_idle) && !age_check_active;
   assign accept = pkt_valid && ready;
   assign hit    = mem_read_data[alut_pkg::valid_bit] &&
                   (mem_read_data[alut_pkg::mac_msb:0] == dst_addr);

   assign add_check_active = accept || (state == st_wait) ||
                             (state == st_result) || (state == st_learn);
   assign lookup_done = (state == st_result);

   // --------------------------------------------------------------------
   // lookup sequencer
   // --------------------------------------------------------------------
   always_comb
   begin
      nxt_state = state;
      case (state)
         st_init:   nxt_state = st_idle;
         st_idle:
            if (accept)
               nxt_state = hit ? st_wait : st_result; // miss skips the query
         st_wait:
            if (age_confirmed)
               nxt_state = st_result;
         st_result: nxt_state = st_learn;
         st_learn:  nxt_state = st_idle;
         default:   nxt_state = st_init;
      endcase
   end

   always_ff @(posedge pclk5 or negedge n_p_reset5)
   begin
      if (!n_p_reset5)
      begin
         state     <= st_init;
         check_age <= 1'b0;
         dst_found <= 1'b0;
      end
      else
      begin
         state     <= nxt_state;
         check_age <= accept && hit;
         if (accept)
            dst_found <= 1'b0;
         else if (state == st_wait && age_confirmed)
            dst_found <= age_ok;                      // found only if in date
      end
   end

   // packet fields and read back entry fields
   always_ff @(posedge pclk5)
   begin
      if (accept)
      begin
         src_addr_q    <= src_addr;
         src_port_q    <= src_port;
         dst_port      <= mem_read_data[alut_pkg::port_msb:alut_pkg::port_lsb];
         last_accessed <= mem_read_data[alut_pkg::time_msb:alut_pkg::time_lsb];
      end
   end

   // --------------------------------------------------------------------
   // table access, dst read on accept, src learn after the result
   // --------------------------------------------------------------------
   assign mem_addr  = (state == st_learn) ? hash_idx(src_addr_q) : hash_idx(dst_addr);
   assign mem_write = (state == st_learn);

   always_comb
   begin
      mem_write_data = '0;
      mem_write_data[alut_pkg::valid_bit] = 1'b1;
      mem_write_data[alut_pkg::time_msb:alut_pkg::time_lsb] = curr_time;
      mem_write_data[alut_pkg::port_msb:alut_pkg::port_lsb] = src_port_q;
      mem_write_data[alut_pkg::mac_msb:0] = src_addr_q;
   end

endmodule

// ==== source/alut_top.sv ====
`timescale 1ns/1ps

module alut_top #(
   parameter int addr_w = 8                           // 2^addr_w table entries
) (
   input  logic                pclk5,
   input  logic                n_p_reset5,
   input  logic                pkt_valid,
   input  logic [47:0]         src_addr,
   input  logic [1:0]          src_port,
   input  logic [47:0]         dst_addr,
   input  alut_pkg::alut_cmd_t command,
   input  logic [7:0]          div_clk,
   input  logic [31:0]         best_bfr_age,
   output logic                ready,
   output logic                lookup_done,
   output logic                dst_found,
   output logic [1:0]          dst_port,
   output logic [31:0]         curr_time,
   output logic                age_check_active,
   output logic                inval_in_prog,
   output logic [47:0]         lst_inv_addr,
   output logic [1:0]          lst_inv_port
);

   // checker to checker
   logic        check_age;
   logic [31:0] last_accessed;
   logic        add_check_active;
   logic        age_confirmed;
   logic        age_ok;

   // memory port
   logic [addr_w-1:0]     chk_addr;
   logic                  chk_write;
   alut_pkg::alut_entry_t chk_wdata;
   logic [addr_w-1:0]     age_addr;
   logic                  age_write;
   alut_pkg::alut_entry_t age_wdata;
   alut_pkg::alut_entry_t read_data;

   alut_mem #(.addr_w(addr_w)) u_mem (
      .pclk5            (pclk5),
      .n_p_reset5       (n_p_reset5),
      .add_check_active (add_check_active),
      .addr_chk_addr    (chk_addr),
      .addr_chk_write   (chk_write),
      .addr_chk_wdata   (chk_wdata),
      .age_addr         (age_addr),
      .age_write        (age_write),
      .age_wdata        (age_wdata),
      .read_data        (read_data)
   );

   alut_age_checker #(.addr_w(addr_w)) u_age_checker (
      .pclk5              (pclk5),
      .n_p_reset5         (n_p_reset5),
      .command            (command),
      .div_clk            (div_clk),
      .mem_read_data      (read_data),
      .check_age          (check_age),
      .last_accessed      (last_accessed),
      .best_bfr_age       (best_bfr_age),
      .add_check_active   (add_check_active),
      .curr_time          (curr_time),
      .mem_addr_age       (age_addr),
      .mem_write_age      (age_write),
      .mem_write_data_age (age_wdata),
      .lst_inv_addr       (lst_inv_addr),
      .lst_inv_port       (lst_inv_port),
      .age_confirmed      (age_confirmed),
      .age_ok             (age_ok),
      .inval_in_prog      (inval_in_prog),
      .age_check_active   (age_check_active)
   );

   alut_addr_checker #(.addr_w(addr_w)) u_addr_checker (
      .pclk5            (pclk5),
      .n_p_reset5       (n_p_reset5),
      .pkt_valid        (pkt_valid),
      .src_addr         (src_addr),
      .src_port         (src_port),
      .dst_addr         (dst_addr),
      .mem_read_data    (read_data),
      .age_confirmed    (age_confirmed),
      .age_ok           (age_ok),
      .age_check_active (age_check_active),
      .curr_time        (curr_time),
      .ready            (ready),
      .lookup_done      (lookup_done),
      .dst_found        (dst_found),
      .dst_port         (dst_port),
      .check_age        (check_age),
      .last_accessed    (last_accessed),
      .add_check_active (add_check_active),
      .mem_addr         (chk_addr),
      .mem_write        (chk_write),
      .mem_write_data   (chk_wdata)
   );

endmodule

// ==== dv/alut_asserts.sv ====
`timescale 1ns/1ps

module alut_asserts (
   input logic                 pclk5,
   input logic                 n_p_reset5,
   input logic                 check_age,
   input logic                 age_confirmed,
   input logic                 mem_write_age,
   input logic                 add_check_active,
   input logic                 lookup_done
);

   int err_cnt = 0;                                   // failure count, polled by the testbench

   // age answer lands two clocks after the query
   age_latency: assert property (@(posedge pclk5) disable iff (!n_p_reset5)
                                 check_age |-> ##2 age_confirmed)
   else
   begin
      $error("age_confirmed missing two cycles after check_age");
      err_cnt++;
   end

   port_owner: assert property (@(posedge pclk5) disable iff (!n_p_reset5)
                                !(mem_write_age && add_check_active))  // single owner
   else
   begin
      $error("age checker wrote the table while the address checker owned it");
      err_cnt++;
   end

   done_width: assert property (@(posedge pclk5) disable iff (!n_p_reset5)
                                lookup_done |=> !lookup_done)
   else
   begin
      $error("lookup_done held longer than one cycle");
      err_cnt++;
   end

endmodule

// ----------------------------------------------------------------------
// attached to both checkers, ports a target lacks are tied off
// ----------------------------------------------------------------------
bind alut_age_checker alut_asserts age_asserts (
   .pclk5, .n_p_reset5, .check_age, .age_confirmed, .mem_write_age,
   .add_check_active, .lookup_done (1'b0)
);

bind alut_addr_checker alut_asserts addr_asserts (
   .pclk5, .n_p_reset5, .check_age, .age_confirmed, .mem_write_age (1'b0),
   .add_check_active, .lookup_done
);

// ==== dv/alut_tb.sv ====
`timescale 1ns/1ps

module alut_tb;

   localparam int          addr_w     = 8;
   localparam int          depth      = 1 << addr_w;
   localparam int          div_val    = 3;            // time step every 4 clocks
   localparam int          test_len   = 4500;         // summed length of all tests
   localparam int          max_cycles = test_len + 4 * depth;
   localparam logic [47:0] probe_mac  = 48'h02aa_0000_0000;   // lookup source, index 0

   logic                pclk5 = 1'b0;
   logic                n_p_reset5;
   logic                pkt_valid;
   logic [47:0]         src_addr;
   logic [1:0]          src_port;
   logic [47:0]         dst_addr;
   alut_pkg::alut_cmd_t command;
   logic [7:0]          div_clk;
   logic [31:0]         best_bfr_age;
   logic                ready;
   logic                lookup_done;
   logic                dst_found;
   logic [1:0]          dst_port;
   logic [31:0]         curr_time;
   logic                age_check_active;
   logic                inval_in_prog;
   logic [47:0]         lst_inv_addr;
   logic [1:0]          lst_inv_port;

   // table model
   logic        m_valid [depth];
   logic [47:0] m_mac   [depth];
   logic [1:0]  m_port  [depth];
   logic [31:0] m_time  [depth];
   int          cycles = 0;                           // clocks since reset release
   logic [47:0] old_q[$];
   logic [47:0] fresh_q[$];

   alut_top #(.addr_w(addr_w)) dut (.*);

   always #4 pclk5 = ~pclk5;

   // cycle count and watchdog
   always @(posedge pclk5)
   begin
      if (n_p_reset5)
         cycles <= cycles + 1;
      if (cycles > max_cycles)
         stop_on_error("timeout, the tests ran past the cycle limit");
   end

   always @(negedge pclk5)
      if (assert_errs() != 0)
         stop_on_error("a bound assertion failed");

   // ----------------------------------------------------------------------
   // reporting and compares
   // ----------------------------------------------------------------------
   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] got);
      stop_on_error($sformatf("Error at %0d ns, %s expected 'h%0h got 'h%0h",
                              $time, name, exp, got));
   endtask

   task automatic check_port(input string name,
                             input logic [alut_pkg::port_msb-alut_pkg::port_lsb:0] exp,
                             input logic [alut_pkg::port_msb-alut_pkg::port_lsb:0] got);
      if (got !== exp)
         value_error(name, 64'(exp), 64'(got));
   endtask

   task automatic check_found(input string name, input logic exp, input logic got);
      if (got !== exp)
         value_error(name, 64'(exp), 64'(got));
   endtask

   task automatic check_mac(input string name, input logic [alut_pkg::mac_msb:0] exp,
                            input logic [alut_pkg::mac_msb:0] got);
      if (got !== exp)
         value_error(name, 64'(exp), 64'(got));
   endtask

   task automatic check_time(input string name,
                             input logic [alut_pkg::time_msb-alut_pkg::time_lsb:0] exp,
                             input logic [alut_pkg::time_msb-alut_pkg::time_lsb:0] got);
      if (got !== exp)
         value_error(name, 64'(exp), 64'(got));
   endtask

   task automatic check_cycles(input string name, input int exp, input int got);
      if (got != exp)
         value_error(name, 64'(exp), 64'(got));
   endtask

   function automatic int assert_errs();
      return dut.u_age_checker.age_asserts.err_cnt + dut.u_addr_checker.addr_asserts.err_cnt;
   endfunction

   // ----------------------------------------------------------------------
   // model rules
   // ----------------------------------------------------------------------
   function automatic logic [addr_w-1:0] index_of(input logic [47:0] mac);
      logic [addr_w-1:0] idx;
      idx = mac[addr_w-1:0];
      idx = idx ^ mac[addr_w +: addr_w];              // fold in the next slice
      return idx;
   endfunction

   function automatic logic [31:0] model_time();
      return 32'(cycles / (div_val + 1));
   endfunction

   function automatic logic in_date(input logic [31:0] stamp, input logic [31:0] now);
      logic [31:0] age;
      age = now - stamp;                              // wraps modulo 2^32
      return best_bfr_age > age;
   endfunction

   function automatic logic [47:0] rand_mac();
      return {16'($urandom), 32'($urandom)};
   endfunction

   // ----------------------------------------------------------------------
   // stimulus
   // ----------------------------------------------------------------------
   task automatic wait_ready();
      @(negedge pclk5);
      while (!ready)
         @(negedge pclk5);                            // bounded by the watchdog
   endtask

   task automatic set_age(input logic [31:0] age);
      @(posedge pclk5);
      best_bfr_age <= age;
      @(negedge pclk5);
   endtask

   task automatic issue_cmd(input alut_pkg::alut_cmd_t cmd);
      wait_ready();
      @(posedge pclk5);
      command <= cmd;
      @(posedge pclk5);
      command <= alut_pkg::cmd_none;                  // one cycle pulse
   endtask

   // one packet, lookup checked against the model, then the learn applied
   task automatic send_pkt(input logic [47:0] src, input logic [1:0] sport,
                           input logic [47:0] dst);
      logic [addr_w-1:0] di;
      logic [addr_w-1:0] si;
      logic              exp_hit;
      logic              exp_found;
      int                n;
      wait_ready();
      @(posedge pclk5);
      pkt_valid <= 1'b1;
      src_addr  <= src;
      src_port  <= sport;
      dst_addr  <= dst;
      @(negedge pclk5);                               // accept cycle
      di        = index_of(dst);
      exp_hit   = m_valid[di] && (m_mac[di] == dst);
      exp_found = exp_hit && in_date(m_time[di], model_time());
      @(posedge pclk5);
      pkt_valid <= 1'b0;
      n = 0;
      do
      begin
         @(negedge pclk5);
         n++;
      end
      while (!lookup_done && n < 8);
      if (!lookup_done)
         stop_on_error("lookup_done did not arrive after a packet");
      check_cycles("lookup latency", exp_hit ? 4 : 1, n);
      check_found("dst_found", exp_found, dst_found);
      if (exp_hit)
         check_port("dst_port", m_port[di], dst_port);
      @(negedge pclk5);                               // learn write cycle
      si          = index_of(src);
      m_valid[si] = 1'b1;
      m_mac[si]   = src;
      m_port[si]  = sport;
      m_time[si]  = model_time();
   endtask

   task automatic learn_set(ref logic [47:0] q[$], input int count);
      repeat (count)
      begin
         q.push_back(rand_mac());
         send_pkt(q[$], 2'($urandom), rand_mac());     // random dst, usually a miss
      end
   endtask

   task automatic apply_reset();
      repeat (4) @(posedge pclk5);
      @(negedge pclk5);
      check_found("ready", 1'b0, ready);
      check_found("lookup_done", 1'b0, lookup_done);
      check_found("age_check_active", 1'b0, age_check_active);
      check_found("inval_in_prog", 1'b0, inval_in_prog);
      @(posedge pclk5);
      n_p_reset5 <= 1'b1;
   endtask

   // ----------------------------------------------------------------------
   // directed tests
   // ----------------------------------------------------------------------
   task automatic time_base();
      repeat (40)
      begin
         @(negedge pclk5);
         check_time("curr_time", model_time(), curr_time);
      end
   endtask

   task automatic learn_and_hit();
      set_age(32'd1000);
      learn_set(fresh_q, 8);
      foreach (fresh_q[i])
         send_pkt(probe_mac, 2'd0, fresh_q[i]);
   endtask

   task automatic miss_and_aging();
      logic [47:0] aged_mac;
      send_pkt(probe_mac, 2'd0, rand_mac());          // never learned
      send_pkt(probe_mac, 2'd0, fresh_q[0] ^ 48'h0101);   // same index, other mac
      set_age(32'd5);
      aged_mac = rand_mac();
      send_pkt(aged_mac, 2'd3, rand_mac());
      repeat (100) @(negedge pclk5);                  // about 25 steps, past best before
      send_pkt(probe_mac, 2'd0, aged_mac);
   endtask

   task automatic inval_aged_sweep();
      logic [47:0] exp_mac;
      logic [1:0]  exp_port;
      logic        exp_prog;
      logic        seen_prog;
      logic [31:0] now;
      fresh_q.delete();
      set_age(32'd400);                               // sweep itself spans about 200 steps
      learn_set(old_q, 6);
      repeat (2400) @(negedge pclk5);                 // old set now 600 steps old
      learn_set(fresh_q, 6);
      exp_mac  = '0;
      exp_port = '0;
      exp_prog = 1'b0;
      now      = model_time();
      for (int i = 0; i < depth; i++)
         if (m_valid[i] && !in_date(m_time[i], now))
         begin
            m_valid[i] = 1'b0;
            exp_mac    = m_mac[i];                    // highest index wins
            exp_port   = m_port[i];
            exp_prog   = exp_prog | (i != depth - 1);
         end
      issue_cmd(alut_pkg::cmd_inval_aged);
      seen_prog = 1'b0;
      do
      begin
         @(negedge pclk5);
         seen_prog = seen_prog | inval_in_prog;
      end
      while (age_check_active);
      check_found("inval_in_prog during sweep", exp_prog, seen_prog);
      check_found("inval_in_prog", 1'b0, inval_in_prog);
      check_mac("lst_inv_addr", exp_mac, lst_inv_addr);
      check_port("lst_inv_port", exp_port, lst_inv_port);
      foreach (old_q[i])
         send_pkt(probe_mac, 2'd0, old_q[i]);
      foreach (fresh_q[i])
         send_pkt(probe_mac, 2'd0, fresh_q[i]);
   endtask

   task automatic inval_all_sweep();
      int n;
      learn_set(fresh_q, 4);
      issue_cmd(alut_pkg::cmd_inval_all);
      n = 0;
      do
      begin
         @(negedge pclk5);
         n++;
      end
      while (age_check_active);
      check_cycles("inval all duration", depth + 1, n);   // counted from the command cycle
      for (int i = 0; i < depth; i++)
         m_valid[i] = 1'b0;
      foreach (old_q[i])
         send_pkt(probe_mac, 2'd0, old_q[i]);
      foreach (fresh_q[i])
         send_pkt(probe_mac, 2'd0, fresh_q[i]);
   endtask

   initial
   begin
      void'($urandom(32'h11f8));                      // seed the random stream
      pkt_valid    = 1'b0;
      src_addr     = '0;
      src_port     = '0;
      dst_addr     = '0;
      command      = alut_pkg::cmd_none;
      div_clk      = 8'(div_val);
      best_bfr_age = 32'd1000;
      n_p_reset5   = 1'b0;
      for (int i = 0; i < depth; i++)
         m_valid[i] = 1'b0;
      apply_reset();
      time_base();
      learn_and_hit();
      miss_and_aging();
      inval_aged_sweep();
      inval_all_sweep();
      @(negedge pclk5);
      if (assert_errs() != 0)
         stop_on_error("a bound assertion failed");
      else
      begin
         $display("Simulation completed successfully");
         $finish;
      end
   end

endmodule

// ==== sim.f ====
source/alut_pkg.sv
source/alut_mem.sv
source/alut_age_checker.sv
source/alut_addr_checker.sv
source/alut_top.sv
dv/alut_asserts.sv
dv/alut_tb.sv
